// File: logic/lsu_pkg.sv
//****************************************
// shared types and constants for the load/store unit
// mem_op_e and req_state_e have fixed widths (4 and 2 bits)
// funct3 and opcode values follow the RV32I base encoding
//****************************************
package lsu_pkg;

  localparam int XLEN = 32;  // data and address width
  localparam int BE_W = 4;   // byte lanes per word

  // RV32I major opcodes
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  // funct3 codes, shared by loads and stores
  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;

  // decoded memory operation
  typedef enum logic [3:0] {
    OP_NONE = 4'd0,
    OP_LB   = 4'd1,
    OP_LH   = 4'd2,
    OP_LW   = 4'd3,
    OP_LBU  = 4'd4,
    OP_LHU  = 4'd5,
    OP_SB   = 4'd6,
    OP_SH   = 4'd7,
    OP_SW   = 4'd8
  } mem_op_e;

  // request bus states
  typedef enum logic [1:0] {
    ST_IDLE        = 2'd0,  // new op accepted here only
    ST_WAIT_GNT    = 2'd1,  // req held, slave not ready
    ST_WAIT_RVALID = 2'd2   // granted, waiting for response
  } req_state_e;

endpackage

// File: logic/mem_bus_if.sv
//****************************************
// request/grant/response data bus
// master holds req and fields until gnt
// one rvalid pulse follows every transfer
//****************************************
`timescale 1ns/1ps

interface mem_bus_if;

  logic                      req;
  logic [lsu_pkg::XLEN-1:0]  addr;   // word aligned byte address
  logic                      we;
  logic [lsu_pkg::BE_W-1:0]  be;
  logic [lsu_pkg::XLEN-1:0]  wdata;
  logic                      gnt;
  logic [lsu_pkg::XLEN-1:0]  rdata;  // valid with rvalid on loads
  logic                      rvalid;

  modport master (
    output req, addr, we, be, wdata,
    input  gnt, rdata, rvalid
  );

  modport slave (
    input  req, addr, we, be, wdata,
    output gnt, rdata, rvalid
  );

endinterface

// File: logic/lsu_op_decode.sv
//****************************************
// decodes the eight RV32I load/store forms
// only opcode and funct3 are examined
// any other word gives OP_NONE
// address below MEM_BASE wraps around
//****************************************
`timescale 1ns/1ps

module lsu_op_decode #(
  parameter logic [31:0] MEM_BASE = 32'h0001_0000
) (
  input  logic [31:0]       instr_i,
  input  logic [31:0]       addr_i,
  output lsu_pkg::mem_op_e  op_o,
  output logic [31:0]       rel_addr_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];

  always_comb begin
    op_o = lsu_pkg::OP_NONE;
    if (opcode == lsu_pkg::OPC_LOAD) begin
      case (funct3)
        lsu_pkg::F3_B:  op_o = lsu_pkg::OP_LB;
        lsu_pkg::F3_H:  op_o = lsu_pkg::OP_LH;
        lsu_pkg::F3_W:  op_o = lsu_pkg::OP_LW;
        lsu_pkg::F3_BU: op_o = lsu_pkg::OP_LBU;
        lsu_pkg::F3_HU: op_o = lsu_pkg::OP_LHU;
        default:        op_o = lsu_pkg::OP_NONE;  // reserved load funct3
      endcase
    end else if (opcode == lsu_pkg::OPC_STORE) begin
      case (funct3)
        lsu_pkg::F3_B: op_o = lsu_pkg::OP_SB;
        lsu_pkg::F3_H: op_o = lsu_pkg::OP_SH;
        lsu_pkg::F3_W: op_o = lsu_pkg::OP_SW;
        default:       op_o = lsu_pkg::OP_NONE;
      endcase
    end
  end

  // byte address as seen by the RAM
  assign rel_addr_o = addr_i - MEM_BASE;

endmodule

// File: logic/lsu_req_fsm.sv
//****************************************
// single outstanding request on the data bus
// issuer must hold op, address and data while stall_o is high
// no misalignment checks; SH ignores address bit 0
// an op still present after rvalid is issued again
//****************************************
`timescale 1ns/1ps

module lsu_req_fsm (
  input  logic                          clk,
  input  logic                          reset,
  input  lsu_pkg::mem_op_e              op_i,
  input  logic [lsu_pkg::XLEN-1:0]      rel_addr_i,
  input  logic [lsu_pkg::XLEN-1:0]      wdata_i,
  mem_bus_if.master                     bus,
  output logic                          resp_valid_o,
  output logic                          stall_o
);

  lsu_pkg::req_state_e          state_q;
  lsu_pkg::req_state_e          state_d;
  logic                         req;
  logic                         is_store;
  logic [lsu_pkg::BE_W-1:0]     store_be;
  logic [lsu_pkg::XLEN-1:0]     store_data;

  assign is_store = (op_i == lsu_pkg::OP_SB) ||
                    (op_i == lsu_pkg::OP_SH) ||
                    (op_i == lsu_pkg::OP_SW);

  // lane placement from the low address bits
  always_comb begin
    store_be   = '0;
    store_data = '0;
    case (op_i)
      lsu_pkg::OP_SB: begin
        store_be   = 4'b0001 << rel_addr_i[1:0];
        store_data = {24'b0, wdata_i[7:0]} << {rel_addr_i[1:0], 3'b000};
      end
      lsu_pkg::OP_SH: begin
        if (rel_addr_i[1]) begin
          store_be   = 4'b1100;
          store_data = {wdata_i[15:0], 16'b0};
        end else begin
          store_be   = 4'b0011;
          store_data = {16'b0, wdata_i[15:0]};
        end
      end
      lsu_pkg::OP_SW: begin
        store_be   = 4'b1111;
        store_data = wdata_i;
      end
      default: ;  // loads and idle drive no lanes
    endcase
  end

  // next state, req and stall
  always_comb begin
    state_d = state_q;
    req     = 1'b0;
    stall_o = 1'b0;
    case (state_q)
      lsu_pkg::ST_IDLE: begin
        if (op_i != lsu_pkg::OP_NONE) begin
          req     = 1'b1;
          stall_o = 1'b1;  // rises in the first cycle of the op
          state_d = bus.gnt ? lsu_pkg::ST_WAIT_RVALID : lsu_pkg::ST_WAIT_GNT;
        end
      end
      lsu_pkg::ST_WAIT_GNT: begin
        req     = 1'b1;
        stall_o = 1'b1;
        if (bus.gnt) begin
          state_d = lsu_pkg::ST_WAIT_RVALID;
        end
      end
      lsu_pkg::ST_WAIT_RVALID: begin
        stall_o = !bus.rvalid;  // released in the response cycle
        if (bus.rvalid) begin
          state_d = lsu_pkg::ST_IDLE;
        end
      end
      default: state_d = lsu_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= lsu_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign bus.req   = req;
  assign bus.addr  = {rel_addr_i[lsu_pkg::XLEN-1:2], 2'b00};
  assign bus.we    = req && is_store;
  assign bus.be    = req ? (is_store ? store_be : '1) : '0;  // loads read whole word
  assign bus.wdata = store_data;

  assign resp_valid_o = (state_q == lsu_pkg::ST_WAIT_RVALID) && bus.rvalid;

endmodule

// File: logic/lsu_load_extract.sv
//****************************************
// byte/halfword select and extension of load data
// purely combinational, valid with resp_valid_i
// halfword uses offset bit 1 only
//****************************************
`timescale 1ns/1ps

module lsu_load_extract (
  input  lsu_pkg::mem_op_e              op_i,
  input  logic [1:0]                    byte_off_i,
  input  logic                          resp_valid_i,
  input  logic [lsu_pkg::XLEN-1:0]      rdata_i,
  output logic [lsu_pkg::XLEN-1:0]      load_data_o,
  output logic                          load_valid_o
);

  logic        is_load;
  logic [31:0] shifted;
  logic [7:0]  sel_byte;
  logic [15:0] sel_half;

  assign is_load = (op_i == lsu_pkg::OP_LB)  ||
                   (op_i == lsu_pkg::OP_LH)  ||
                   (op_i == lsu_pkg::OP_LW)  ||
                   (op_i == lsu_pkg::OP_LBU) ||
                   (op_i == lsu_pkg::OP_LHU);

  assign shifted  = rdata_i >> {byte_off_i, 3'b000};
  assign sel_byte = shifted[7:0];
  assign sel_half = byte_off_i[1] ? rdata_i[31:16] : rdata_i[15:0];

  assign load_valid_o = resp_valid_i && is_load;

  always_comb begin
    load_data_o = '0;
    if (load_valid_o) begin
      case (op_i)
        lsu_pkg::OP_LB:  load_data_o = {{24{sel_byte[7]}}, sel_byte};
        lsu_pkg::OP_LH:  load_data_o = {{16{sel_half[15]}}, sel_half};
        lsu_pkg::OP_LBU: load_data_o = {24'b0, sel_byte};
        lsu_pkg::OP_LHU: load_data_o = {16'b0, sel_half};
        lsu_pkg::OP_LW:  load_data_o = rdata_i;
        default:         load_data_o = '0;
      endcase
    end
  end

endmodule

// File: logic/data_ram.sv
//****************************************
// word-addressed data RAM on the request bus
// DEPTH_WORDS must be a power of two, at least 2
// upper address bits are ignored, so accesses wrap
// GNT_DELAY 0..7 cycles of held req before gnt
// rvalid one cycle after every grant
// only word 0 is cleared by reset
//****************************************
`timescale 1ns/1ps

module data_ram #(
  parameter int DEPTH_WORDS = 1024,
  parameter int GNT_DELAY   = 1
) (
  input  logic                      clk,
  input  logic                      reset,
  mem_bus_if.slave                  bus,
  output logic [lsu_pkg::XLEN-1:0]  watch_o
);

  localparam int         AW      = $clog2(DEPTH_WORDS);
  localparam logic [2:0] GNT_CNT = 3'(GNT_DELAY);

  logic [lsu_pkg::XLEN-1:0] mem [DEPTH_WORDS];
  logic [AW-1:0]            word_idx;
  logic [2:0]               wait_cnt;
  logic                     rvalid_q;
  logic [lsu_pkg::XLEN-1:0] rdata_q;

  assign word_idx = bus.addr[AW+1:2];

  // grant once req has been held GNT_DELAY cycles
  assign bus.gnt = bus.req && (wait_cnt == GNT_CNT);

  always_ff @(posedge clk) begin
    if (reset) begin
      wait_cnt <= '0;
    end else if (bus.req && !bus.gnt) begin
      wait_cnt <= wait_cnt + 3'd1;
    end else begin
      wait_cnt <= '0;  // cleared after each transfer
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.gnt;  // reads and writes both answer
    end
  end

  always_ff @(posedge clk) begin
    if (bus.gnt && !bus.we) begin
      rdata_q <= mem[word_idx];
    end
  end

  // byte-lane writes
  always_ff @(posedge clk) begin
    if (reset) begin
      mem[0] <= '0;
    end else if (bus.gnt && bus.we) begin
      for (int b = 0; b < lsu_pkg::BE_W; b++) begin
        if (bus.be[b]) begin
          mem[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign watch_o    = mem[0];  // end-of-program tap

endmodule

// File: logic/lsu_top.sv
//****************************************
// load/store unit with its data RAM
// inputs must stay stable while stall_o is high
// load result valid for one cycle with load_valid_o
// watch_o shows RAM word 0 (address MEM_BASE)
//****************************************
`timescale 1ns/1ps

module lsu_top #(
  parameter logic [31:0] MEM_BASE    = 32'h0001_0000,
  parameter int          DEPTH_WORDS = 1024,
  parameter int          GNT_DELAY   = 1
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] instr_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  output logic [31:0] load_data_o,
  output logic        load_valid_o,
  output logic        stall_o,
  output logic [31:0] watch_o
);

  lsu_pkg::mem_op_e op;
  logic [31:0]      rel_addr;
  logic             resp_valid;

  mem_bus_if mem_bus ();

  lsu_op_decode #(
    .MEM_BASE (MEM_BASE)
  ) u_decode (
    .instr_i    (instr_i),
    .addr_i     (addr_i),
    .op_o       (op),
    .rel_addr_o (rel_addr)
  );

  lsu_req_fsm u_req_fsm (
    .clk          (clk),
    .reset        (reset),
    .op_i         (op),
    .rel_addr_i   (rel_addr),
    .wdata_i      (wdata_i),
    .bus          (mem_bus.master),
    .resp_valid_o (resp_valid),
    .stall_o      (stall_o)
  );

  lsu_load_extract u_extract (
    .op_i         (op),
    .byte_off_i   (rel_addr[1:0]),
    .resp_valid_i (resp_valid),
    .rdata_i      (mem_bus.rdata),
    .load_data_o  (load_data_o),
    .load_valid_o (load_valid_o)
  );

  data_ram #(
    .DEPTH_WORDS (DEPTH_WORDS),
    .GNT_DELAY   (GNT_DELAY)
  ) u_ram (
    .clk     (clk),
    .reset   (reset),
    .bus     (mem_bus.slave),
    .watch_o (watch_o)
  );

endmodule

// File: verif/lsu_properties.sv
//****************************************
// bus and stall assertions, bound into lsu_req_fsm
// stall drops in the rvalid cycle, so that cycle is exempt
//****************************************
`timescale 1ns/1ps

module lsu_properties (
  input logic                clk,
  input logic                reset,
  input lsu_pkg::req_state_e state_i,
  input logic                req_i,
  input logic [31:0]         addr_i,
  input logic                gnt_i,
  input logic                rvalid_i,
  input logic                stall_i
);

  // request and address held until the slave grants
  req_held_a: assert property (
    @(posedge clk) disable iff (reset)
    (req_i && !gnt_i) |=> (req_i && $stable(addr_i))
  ) else $error("req dropped or addr changed before gnt");

  no_idle_rvalid_a: assert property (
    @(posedge clk) disable iff (reset)
    (state_i == lsu_pkg::ST_IDLE) |-> !rvalid_i
  ) else $error("rvalid while the request FSM is idle");

  // a stalled cycle without response leaves the FSM busy and still stalled
  busy_stall_a: assert property (
    @(posedge clk) disable iff (reset)
    (stall_i && !rvalid_i) |=> ((state_i != lsu_pkg::ST_IDLE) && (stall_i || rvalid_i))
  ) else $error("request FSM went idle or dropped stall before rvalid");

endmodule

bind lsu_req_fsm lsu_properties u_props (
  .clk      (clk),
  .reset    (reset),
  .state_i  (state_q),
  .req_i    (bus.req),
  .addr_i   (bus.addr),
  .gnt_i    (bus.gnt),
  .rvalid_i (bus.rvalid),
  .stall_i  (stall_o)
);

// File: verif/lsu_tb.sv
//****************************************
// table-driven testbench for lsu_top
// test addresses stay within the first 16 RAM words
// each row ends with one idle cycle before the next
//****************************************
`timescale 1ns/1ps

module lsu_tb;

  localparam logic [31:0] MEM_BASE     = 32'h0001_0000;
  localparam int          DEPTH_WORDS  = 256;
  localparam int          GNT_DELAY    = 2;
  localparam int          N_ROWS       = 23;
  localparam int          RESET_CYCLES = 8;
  localparam int          CYCLE_LIMIT  = N_ROWS * (GNT_DELAY + 4) + RESET_CYCLES;
  localparam logic [31:0] NOP          = 32'h0000_0013;  // addi x0, x0, 0

  logic        clk;
  logic        reset;
  logic [31:0] instr_i, addr_i, wdata_i;
  logic [31:0] load_data_o, watch_o;
  logic        load_valid_o, stall_o;

  string       row_name  [N_ROWS];
  logic [31:0] row_instr [N_ROWS];
  logic [31:0] row_addr  [N_ROWS];
  logic [31:0] row_wdata [N_ROWS];
  logic [31:0] exp_data  [N_ROWS];
  logic [31:0] exp_watch [N_ROWS];
  logic        exp_valid [N_ROWS];
  logic        exp_busy  [N_ROWS];  // stall in the first cycle of the row
  logic [31:0] ref_mem   [16];  // expected RAM contents
  int          n_rows = 0;
  int          errors = 0;
  int          cycle_cnt = 0;
  integer      seed = 10;

  lsu_top #(
    .MEM_BASE    (MEM_BASE),
    .DEPTH_WORDS (DEPTH_WORDS),
    .GNT_DELAY   (GNT_DELAY)
  ) UUT (
    .clk          (clk),
    .reset        (reset),
    .instr_i      (instr_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .load_data_o  (load_data_o),
    .load_valid_o (load_valid_o),
    .stall_o      (stall_o),
    .watch_o      (watch_o)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: no result after %0d cycles", CYCLE_LIMIT);
      $display("Something failed");
      $finish;
    end
  end

  function automatic logic [31:0] load_instr(input logic [2:0] f3);
    return {12'h004, 5'd1, f3, 5'd2, lsu_pkg::OPC_LOAD};
  endfunction

  function automatic logic [31:0] store_instr(input logic [2:0] f3);
    return {7'h00, 5'd3, 5'd1, f3, 5'd4, lsu_pkg::OPC_STORE};
  endfunction

  task automatic add_row(input string name, input logic [31:0] instr,
                         input logic [31:0] offset, input logic [31:0] wdata,
                         input logic rnd);
    row_name[n_rows]  = name;
    row_instr[n_rows] = instr;
    row_addr[n_rows]  = MEM_BASE + offset;
    row_wdata[n_rows] = wdata;
    if (rnd) begin
      row_wdata[n_rows] = $random(seed);
    end
    n_rows++;
  endtask

  // expected result of row i, following the lane and extension rules
  task automatic model_row(input int i);
    logic [31:0] rel;
    logic [31:0] word;
    logic [7:0]  b;
    logic [15:0] h;
    rel  = row_addr[i] - MEM_BASE;
    word = ref_mem[rel[5:2]];
    b    = word[8*rel[1:0] +: 8];
    h    = word[16*rel[1] +: 16];
    exp_valid[i] = 1'b0;
    exp_busy[i]  = 1'b0;
    exp_data[i]  = '0;
    if (row_instr[i][6:0] == lsu_pkg::OPC_STORE) begin
      exp_busy[i] = 1'b1;
      case (row_instr[i][14:12])
        lsu_pkg::F3_B: word[8*rel[1:0] +: 8] = row_wdata[i][7:0];
        lsu_pkg::F3_H: word[16*rel[1] +: 16] = row_wdata[i][15:0];
        lsu_pkg::F3_W: word = row_wdata[i];
        default:       exp_busy[i] = 1'b0;  // not a store form
      endcase
      ref_mem[rel[5:2]] = word;
    end else if (row_instr[i][6:0] == lsu_pkg::OPC_LOAD) begin
      exp_valid[i] = 1'b1;
      case (row_instr[i][14:12])
        lsu_pkg::F3_B:  exp_data[i] = {{24{b[7]}}, b};
        lsu_pkg::F3_H:  exp_data[i] = {{16{h[15]}}, h};
        lsu_pkg::F3_W:  exp_data[i] = word;
        lsu_pkg::F3_BU: exp_data[i] = {24'b0, b};
        lsu_pkg::F3_HU: exp_data[i] = {16'b0, h};
        default:        exp_valid[i] = 1'b0;  // not a load form
      endcase
      exp_busy[i] = exp_valid[i];
    end
    exp_watch[i] = ref_mem[0];
  endtask

  task automatic compare_word(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", what, expected, actual);
    end
  endtask

  initial begin
    reset   = 1'b1;
    instr_i = NOP;
    addr_i  = MEM_BASE;
    wdata_i = '0;
    for (int w = 0; w < 16; w++) begin
      ref_mem[w] = '0;
    end
    add_row("sw_watch",   store_instr(lsu_pkg::F3_W), 32'h0, 32'h0, 1'b1);
    add_row("lw_watch",   load_instr(lsu_pkg::F3_W),  32'h0, 32'h0, 1'b0);
    add_row("sw_word1",   store_instr(lsu_pkg::F3_W), 32'h4, 32'h0, 1'b1);
    add_row("lw_word1",   load_instr(lsu_pkg::F3_W),  32'h4, 32'h0, 1'b0);
    add_row("sw_clear2",  store_instr(lsu_pkg::F3_W), 32'h8, 32'h0, 1'b0);
    add_row("sb_lane0",   store_instr(lsu_pkg::F3_B), 32'h8, 32'h0, 1'b1);
    add_row("sb_lane2",   store_instr(lsu_pkg::F3_B), 32'hA, 32'h0000_0042, 1'b0);
    add_row("lw_lanes02", load_instr(lsu_pkg::F3_W),  32'h8, 32'h0, 1'b0);
    add_row("sb_lane1",   store_instr(lsu_pkg::F3_B), 32'h9, 32'hFFFF_FF80, 1'b0);
    add_row("sb_lane3",   store_instr(lsu_pkg::F3_B), 32'hB, 32'h0, 1'b1);
    add_row("lw_lanes",   load_instr(lsu_pkg::F3_W),  32'h8, 32'h0, 1'b0);
    add_row("lb_neg",     load_instr(lsu_pkg::F3_B),  32'h9, 32'h0, 1'b0);
    add_row("lbu_neg",    load_instr(lsu_pkg::F3_BU), 32'h9, 32'h0, 1'b0);
    add_row("lb_pos",     load_instr(lsu_pkg::F3_B),  32'hA, 32'h0, 1'b0);
    add_row("sh_low",     store_instr(lsu_pkg::F3_H), 32'hC, 32'h1234_8001, 1'b0);
    add_row("sh_high",    store_instr(lsu_pkg::F3_H), 32'hE, 32'h0, 1'b1);
    add_row("lh_low",     load_instr(lsu_pkg::F3_H),  32'hC, 32'h0, 1'b0);
    add_row("lhu_low",    load_instr(lsu_pkg::F3_HU), 32'hC, 32'h0, 1'b0);
    add_row("lh_high",    load_instr(lsu_pkg::F3_H),  32'hE, 32'h0, 1'b0);
    add_row("lhu_high",   load_instr(lsu_pkg::F3_HU), 32'hE, 32'h0, 1'b0);
    add_row("nop_addi",   NOP,                        32'h0, 32'h0, 1'b0);
    add_row("bad_load",   load_instr(3'b011),         32'h0, 32'h0, 1'b0);
    add_row("sw_unwatch", store_instr(lsu_pkg::F3_W), 32'h0, 32'h0, 1'b0);
    for (int i = 0; i < N_ROWS; i++) begin
      model_row(i);
    end

    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    compare_word("after_reset stall_o", 32'h0, {31'b0, stall_o});
    compare_word("after_reset load_valid_o", 32'h0, {31'b0, load_valid_o});
    compare_word("after_reset watch_o", 32'h0, watch_o);

    for (int i = 0; i < N_ROWS; i++) begin
      @(posedge clk);
      instr_i <= row_instr[i];
      addr_i  <= row_addr[i];
      wdata_i <= row_wdata[i];
      @(negedge clk);
      compare_word({row_name[i], " stall_o"}, {31'b0, exp_busy[i]}, {31'b0, stall_o});
      while (stall_o) begin
        if (load_valid_o) begin
          errors++;
          $display("load_valid_o was high while stalled in %s", row_name[i]);
        end
        @(negedge clk);
      end
      // stall has fallen, response cycle
      compare_word({row_name[i], " load_valid_o"}, {31'b0, exp_valid[i]},
                   {31'b0, load_valid_o});
      compare_word({row_name[i], " load_data_o"}, exp_data[i], load_data_o);
      compare_word({row_name[i], " watch_o"}, exp_watch[i], watch_o);
      @(posedge clk);
      instr_i <= NOP;
      @(negedge clk);
      if (stall_o || load_valid_o) begin
        errors++;
        $display("stall_o or load_valid_o stayed high after %s", row_name[i]);
      end
    end

    $display("rows: %0d  errors: %0d", n_rows, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: sources.f
logic/lsu_pkg.sv
logic/mem_bus_if.sv
logic/lsu_op_decode.sv
logic/lsu_req_fsm.sv
logic/lsu_load_extract.sv
logic/data_ram.sv
logic/lsu_top.sv
verif/lsu_properties.sv
verif/lsu_tb.sv

// File: Makefile
# Verilator build and run for the load/store unit testbench

VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Everything OK

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
